// File: logic/cpuPkg.sv
package cpuPkg;

    localparam int XLEN = 32;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OpR      = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpAuipc  = 7'b0010111
    } opcodeE;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt
    } aluOpE;

    typedef enum logic [2:0] {
        ImmI,
        ImmS,
        ImmB,
        ImmU,
        ImmJ
    } immSrcE;

    typedef enum logic [1:0] {
        ResAlu,
        ResMem,
        ResPc4
    } resultSrcE;

    // funct3 / funct7 codes
    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Slt    = 3'b010;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;
    localparam logic [2:0] F3Byte   = 3'b000;
    localparam logic [2:0] F3Lbu    = 3'b100;
    localparam logic [2:0] F3Bne    = 3'b001;
    localparam logic [6:0] F7Base   = 7'b0000000;
    localparam logic [6:0] F7Sub    = 7'b0100000;

endpackage

// File: logic/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
    import cpuPkg::*;

    logic      regWrite;
    aluOpE     aluCtrl;
    logic      aluSrc;     // 1 selects the immediate
    immSrcE    immSrc;
    logic      memWrite;
    resultSrcE resultSrc;
    logic      pcSrc;      // Redirect the PC
    logic      jalr;       // Redirect target comes from the ALU
    logic      pcOperand;  // ALU operand a is the PC

    modport ctrl (output regWrite, aluCtrl, aluSrc, immSrc, memWrite,
                  resultSrc, pcSrc, jalr, pcOperand);
    modport dp (input regWrite, aluCtrl, aluSrc, immSrc, memWrite,
                resultSrc, pcSrc, jalr, pcOperand);
endinterface

// File: logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic [31:0] instr,
    input  logic        zero,
    ctrlIf.ctrl         ctrlPort
);
    import cpuPkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcodeE'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        // Everything inactive unless a supported encoding matches
        ctrlPort.regWrite  = 1'b0;
        ctrlPort.aluCtrl   = AluAdd;
        ctrlPort.aluSrc    = 1'b0;
        ctrlPort.immSrc    = ImmI;
        ctrlPort.memWrite  = 1'b0;
        ctrlPort.resultSrc = ResAlu;
        ctrlPort.pcSrc     = 1'b0;
        ctrlPort.jalr      = 1'b0;
        ctrlPort.pcOperand = 1'b0;

        case (opcode)
            OpR: begin
                ctrlPort.regWrite = 1'b1;
                if (funct3 == F3AddSub && funct7 == F7Base) ctrlPort.aluCtrl = AluAdd;
                else if (funct3 == F3AddSub && funct7 == F7Sub) ctrlPort.aluCtrl = AluSub;
                else if (funct3 == F3And && funct7 == F7Base) ctrlPort.aluCtrl = AluAnd;
                else if (funct3 == F3Or && funct7 == F7Base) ctrlPort.aluCtrl = AluOr;
                else if (funct3 == F3Slt && funct7 == F7Base) ctrlPort.aluCtrl = AluSlt;
                else ctrlPort.regWrite = 1'b0;  // Unsupported R-type
            end
            OpImm: begin
                if (funct3 == F3AddSub) begin  // addi
                    ctrlPort.regWrite = 1'b1;
                    ctrlPort.aluSrc   = 1'b1;
                end
            end
            OpLoad: begin
                if (funct3 == F3Lbu) begin
                    ctrlPort.regWrite  = 1'b1;
                    ctrlPort.aluSrc    = 1'b1;
                    ctrlPort.resultSrc = ResMem;
                end
            end
            OpStore: begin
                if (funct3 == F3Byte) begin  // sb
                    ctrlPort.memWrite = 1'b1;
                    ctrlPort.aluSrc   = 1'b1;
                    ctrlPort.immSrc   = ImmS;
                end
            end
            OpBranch: begin
                if (funct3 == F3Bne) begin
                    ctrlPort.aluCtrl = AluSub;
                    ctrlPort.immSrc  = ImmB;
                    ctrlPort.pcSrc   = ~zero;  // Taken when operands differ
                end
            end
            OpJal: begin
                ctrlPort.regWrite  = 1'b1;
                ctrlPort.immSrc    = ImmJ;
                ctrlPort.pcSrc     = 1'b1;
                ctrlPort.resultSrc = ResPc4;
            end
            OpJalr: begin
                if (funct3 == F3AddSub) begin
                    ctrlPort.regWrite  = 1'b1;
                    ctrlPort.aluSrc    = 1'b1;
                    ctrlPort.pcSrc     = 1'b1;
                    ctrlPort.jalr      = 1'b1;
                    ctrlPort.resultSrc = ResPc4;
                end
            end
            OpAuipc: begin
                ctrlPort.regWrite  = 1'b1;
                ctrlPort.aluSrc    = 1'b1;
                ctrlPort.immSrc    = ImmU;
                ctrlPort.pcOperand = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        pcSrcOnlyForFlow: assert final (!ctrlPort.pcSrc ||
                                        opcode inside {OpBranch, OpJal, OpJalr});
        noWriteAndStore: assert final (!(ctrlPort.regWrite && ctrlPort.memWrite));
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                     clk,
    input  logic                     rstN,
    ctrlIf.dp                        ctrlPort,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic [cpuPkg::XLEN-1:0]  wdata,
    output logic [cpuPkg::XLEN-1:0]  rdata1,
    output logic [cpuPkg::XLEN-1:0]  rdata2
);
    import cpuPkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrlPort.regWrite && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads its cleared entry
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    x0StaysZero: assert property (@(posedge clk) disable iff (!rstN) regs[0] == '0);

endmodule

// File: logic/immGen.sv
`timescale 1ns/1ps

module immGen (
    input  logic [31:0]              instr,
    input  cpuPkg::immSrcE           immSrc,
    output logic [cpuPkg::XLEN-1:0]  imm
);
    import cpuPkg::*;

    always_comb begin
        case (immSrc)
            ImmI: imm = {{20{instr[31]}}, instr[31:20]};
            ImmS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offsets are in halfwords
            ImmB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
            ImmU: imm = {instr[31:12], 12'b0};
            ImmJ: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpuPkg::XLEN-1:0]  a,
    input  logic [cpuPkg::XLEN-1:0]  b,
    input  cpuPkg::aluOpE            aluCtrl,
    output logic [cpuPkg::XLEN-1:0]  y,
    output logic                     zero
);
    import cpuPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluCtrl)
            AluAdd:  y = a + b;
            AluSub:  y = a - b;
            AluAnd:  y = a & b;
            AluOr:   y = a | b;
            AluSlt:  y = {{(XLEN-1){1'b0}}, lessThan};
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);  // Used by bne

endmodule

// File: logic/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
    parameter int MemBytes = 1024
) (
    input  logic                     clk,
    ctrlIf.dp                        ctrlPort,
    input  logic [cpuPkg::XLEN-1:0]  addr,
    input  logic [7:0]               wdata,
    output logic [cpuPkg::XLEN-1:0]  rdata
);
    import cpuPkg::*;

    localparam int AddrBits = $clog2(MemBytes);

    logic [7:0]          mem [MemBytes];
    logic [AddrBits-1:0] idx;

    assign idx = addr[AddrBits-1:0];  // Wraps modulo MemBytes

    always_ff @(posedge clk) begin
        if (ctrlPort.memWrite) begin
            mem[idx] <= wdata;
        end
    end

    // lbu zero-extends
    assign rdata = {{(XLEN-8){1'b0}}, mem[idx]};

    storeAddrKnown: assert property (@(posedge clk)
        ctrlPort.memWrite |-> !$isunknown(addr));

endmodule

// File: logic/pcUnit.sv
`timescale 1ns/1ps

module pcUnit #(
    parameter logic [cpuPkg::XLEN-1:0] ResetPc = '0
) (
    input  logic                     clk,
    input  logic                     rstN,
    ctrlIf.dp                        ctrlPort,
    input  logic [cpuPkg::XLEN-1:0]  imm,
    input  logic [cpuPkg::XLEN-1:0]  aluY,
    output logic [cpuPkg::XLEN-1:0]  pc,
    output logic [cpuPkg::XLEN-1:0]  pcPlus4
);
    import cpuPkg::*;

    logic [XLEN-1:0] pcNext;

    assign pcPlus4 = pc + XLEN'(4);

    always_comb begin
        if (!ctrlPort.pcSrc) pcNext = pcPlus4;
        else if (!ctrlPort.jalr) pcNext = pc + imm;  // bne and jal
        else pcNext = {aluY[XLEN-1:1], 1'b0};
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) pc <= ResetPc;
        else pc <= pcNext;
    end

    pcWordAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

// File: logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
    parameter int                      MemBytes = 1024,
    parameter logic [cpuPkg::XLEN-1:0] ResetPc  = '0
) (
    input  logic                     clk,
    input  logic                     rstN,
    output logic [cpuPkg::XLEN-1:0]  instrAddr,
    input  logic [31:0]              instr,
    output logic                     wbEn,
    output logic [4:0]               wbRd,
    output logic [cpuPkg::XLEN-1:0]  wbData
);
    import cpuPkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] aluA;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluY;
    logic [XLEN-1:0] memRdata;
    logic [XLEN-1:0] result;
    logic            zero;

    ctrlIf ctrlBus ();

    controlUnit ctrl0 (.instr(instr), .zero(zero), .ctrlPort(ctrlBus));

    regFile regs0 (.clk(clk), .rstN(rstN), .ctrlPort(ctrlBus), .rs1(instr[19:15]),
                   .rs2(instr[24:20]), .rd(instr[11:7]), .wdata(result),
                   .rdata1(rdata1), .rdata2(rdata2));

    immGen imm0 (.instr(instr), .immSrc(ctrlBus.immSrc), .imm(imm));

    assign aluA = ctrlBus.pcOperand ? pc : rdata1;  // auipc
    assign aluB = ctrlBus.aluSrc ? imm : rdata2;

    alu alu0 (.a(aluA), .b(aluB), .aluCtrl(ctrlBus.aluCtrl), .y(aluY), .zero(zero));

    dataMem #(.MemBytes(MemBytes)) mem0 (.clk(clk), .ctrlPort(ctrlBus), .addr(aluY),
                                         .wdata(rdata2[7:0]), .rdata(memRdata));

    pcUnit #(.ResetPc(ResetPc)) pc0 (.clk(clk), .rstN(rstN), .ctrlPort(ctrlBus), .imm(imm),
                                     .aluY(aluY), .pc(pc), .pcPlus4(pcPlus4));

    always_comb begin
        case (ctrlBus.resultSrc)
            ResMem:  result = memRdata;
            ResPc4:  result = pcPlus4;   // Link address
            default: result = aluY;
        endcase
    end

    assign instrAddr = pc;
    assign wbEn      = ctrlBus.regWrite;
    assign wbRd      = instr[11:7];
    assign wbData    = result;

endmodule

// File: bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    localparam int ClkPeriod = 100;
    localparam int ImemWords = 32;
    localparam logic [6:0] OpcR     = 7'h33;
    localparam logic [6:0] OpcImm   = 7'h13;
    localparam logic [6:0] OpcLoad  = 7'h03;
    localparam logic [6:0] OpcJalr  = 7'h67;
    localparam logic [6:0] OpcAuipc = 7'h17;
    localparam logic [6:0] OpcLui   = 7'h37;

    typedef struct packed {
        logic [31:0] addr;
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } stepT;

    logic        clk;
    logic        rstN;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic        wbEn;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    logic [31:0] imem [ImemWords];
    logic [31:0] rf [32];          // Reference register model
    stepT        steps [$];
    int          errors;
    int          timeouts;
    int unsigned lcgState = 44;

    cpuTop #(.MemBytes(1024), .ResetPc('0)) dut0 (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData)
    );

    // ROM lookup returns zero in reset or past the program
    assign instr = (rstN && instrAddr < ImemWords * 4) ? imem[instrAddr[6:2]] : '0;

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 1103515245 + 12345;
        return lcgState >> 16;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OpcR};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encSb(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encBne(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJal(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    // Writing step updates the model and queues the expected trace
    task automatic emitWb(input logic [31:0] pc, input logic [31:0] word,
                          input logic [31:0] value);
        logic [4:0] rd;
        rd = word[11:7];
        imem[pc[6:2]] = word;
        steps.push_back({pc, 1'b1, rd, value});
        if (rd != 5'd0) rf[rd] = value;
    endtask

    task automatic emitQuiet(input logic [31:0] pc, input logic [31:0] word);
        imem[pc[6:2]] = word;
        steps.push_back({pc, 1'b0, 5'd0, 32'd0});
    endtask

    task automatic buildProgram();
        logic [11:0] immA;
        logic [11:0] immB;
        logic [7:0]  memByte;
        int          mag;
        for (int i = 0; i < ImemWords; i++) imem[i] = '0;
        for (int i = 0; i < 32; i++) rf[i] = '0;
        immA = 12'(1 + int'(lcgNext() % 100));   // Positive
        mag = 1 + int'(lcgNext() % 100);
        immB = 12'(-mag);                         // Negative
        emitWb(0, encI(immA, 0, 3'b000, 1, OpcImm), rf[0] + sext12(immA));
        emitWb(4, encI(immB, 0, 3'b000, 2, OpcImm), rf[0] + sext12(immB));
        emitWb(8, encI(12'd5, 0, 3'b000, 0, OpcImm), 32'd5);   // addi to x0
        emitWb(12, encR(7'h00, 2, 1, 3'b000, 3), rf[1] + rf[2]);
        emitWb(16, encR(7'h20, 2, 1, 3'b000, 4), rf[1] - rf[2]);
        emitWb(20, encR(7'h00, 2, 1, 3'b111, 5), rf[1] & rf[2]);
        emitWb(24, encR(7'h00, 2, 1, 3'b110, 6), rf[1] | rf[2]);
        emitWb(28, encR(7'h00, 1, 2, 3'b010, 7), 32'd1);   // negative < positive
        emitWb(32, encR(7'h00, 2, 1, 3'b010, 8), 32'd0);
        emitWb(36, encR(7'h00, 1, 0, 3'b000, 9), rf[0] + rf[1]);
        emitWb(40, encI(12'h1A5, 0, 3'b000, 10, OpcImm), 32'h1A5);
        emitWb(44, encI(12'd64, 0, 3'b000, 11, OpcImm), 32'd64);
        emitQuiet(48, encSb(12'd3, 10, 11));
        memByte = rf[10][7:0];
        emitWb(52, encI(12'd3, 11, 3'b100, 12, OpcLoad), {24'd0, memByte});
        emitQuiet(56, encBne(13'd12, 2, 1));       // Taken forward to 68
        emitQuiet(68, encBne(13'(-8), 0, 1));      // Taken backward to 60
        emitQuiet(60, encBne(13'd40, 0, 0));       // Equal, falls through
        emitWb(64, encJal(21'd16, 14), 32'd68);    // Jumps to 80
        emitWb(80, {20'h12345, 5'd15, OpcAuipc}, 32'd80 + 32'h12345000);
        emitWb(84, encI(12'd96, 0, 3'b000, 16, OpcImm), 32'd96);
        emitWb(88, encI(12'd5, 16, 3'b000, 17, OpcJalr), 32'd92);  // 101 -> 100
        emitQuiet(100, {20'h00001, 5'd18, OpcLui});  // Unsupported
        emitWb(104, encR(7'h00, 14, 17, 3'b000, 19), rf[17] + rf[14]);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic waitFall(output bit ok);
        bit seenHigh;
        ok = 1'b0;
        seenHigh = 1'b0;
        for (int t = 0; t < 2 * ClkPeriod && !ok; t++) begin
            #1;
            if (clk === 1'b1) seenHigh = 1'b1;
            else if (seenHigh) ok = 1'b1;
        end
        if (!ok) begin
            $display("Timeout: no falling clock edge within %0d ns", 2 * ClkPeriod);
            timeouts++;
            errors++;
        end
    endtask

    initial begin
        bit   ok;
        stepT s;
        errors = 0;
        timeouts = 0;
        rstN = 1'b0;
        ok = 1'b1;
        buildProgram();
        for (int i = 0; i < 4 && ok; i++) waitFall(ok);
        rstN = 1'b1;
        for (int i = 0; i < steps.size() && ok; i++) begin
            s = steps[i];
            #1;  // Decode settles after the PC or reset change
            checkValue("instrAddr", s.addr, instrAddr);
            checkValue("wbEn", {31'd0, s.en}, {31'd0, wbEn});
            if (s.en) begin
                checkValue("wbRd", {27'd0, s.rd}, {27'd0, wbRd});
                checkValue("wbData", s.data, wbData);
            end
            waitFall(ok);
        end
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
logic/cpuPkg.sv
logic/ctrlIf.sv
logic/controlUnit.sv
logic/regFile.sv
logic/immGen.sv
logic/alu.sv
logic/dataMem.sv
logic/pcUnit.sv
logic/cpuTop.sv
bench/cpuTb.sv

// File: Bender.yml
package:
  name: rv32i_subset

sources:
  - logic/cpuPkg.sv
  - logic/ctrlIf.sv
  - logic/controlUnit.sv
  - logic/regFile.sv
  - logic/immGen.sv
  - logic/alu.sv
  - logic/dataMem.sv
  - logic/pcUnit.sv
  - logic/cpuTop.sv
  - target: simulation
    files:
      - bench/cpuTb.sv
